// File: rtl/sdram_sched_pkg.sv
// timing values are cycles minus one and every counter reload must fit in W_TIME bits
package sdram_sched_pkg;

	// --------------------
	// command encodings
	// --------------------
	// bit order is ras_n cas_n we_n
	typedef enum logic [2:0] {
		CMD_REFRESH   = 3'b001,
		CMD_PRECHARGE = 3'b010,
		CMD_ACTIVATE  = 3'b011,
		CMD_WRITE     = 3'b100,
		CMD_READ      = 3'b101
	} sdram_cmd_e;

	// address geometry
	localparam int W_ROW   = 13;
	localparam int W_BANK  = 2;
	localparam int W_COL   = 10;
	localparam int N_BANKS = 1 << W_BANK;

	// fixed burst shape
	localparam int BURST_LEN         = 8;
	localparam int CAS_LATENCY       = 2;
	// A10 selects all banks on precharge
	localparam int PRECHARGE_ALL_BIT = 10;

	// --------------------
	// timing rules
	// --------------------
	localparam int W_TIME = 4;
	// row cycle, same bank
	localparam logic [W_TIME-1:0] T_RC  = 4'd5;
	// activate to read or write
	localparam logic [W_TIME-1:0] T_RCD = 4'd1;
	// precharge to activate
	localparam logic [W_TIME-1:0] T_RP  = 4'd1;
	// activate to activate, any bank
	localparam logic [W_TIME-1:0] T_RRD = 4'd1;
	// activate to precharge
	localparam logic [W_TIME-1:0] T_RAS = 4'd4;
	// write recovery
	localparam logic [W_TIME-1:0] T_WR  = 4'd1;

	// burst end to precharge, counted from the column command
	localparam logic [W_TIME-1:0] T_WR_RECOVERY = W_TIME'(BURST_LEN + T_WR);
	localparam logic [W_TIME-1:0] T_RD_RECOVERY = W_TIME'(BURST_LEN + CAS_LATENCY);

	// refresh pacing, kept short for simulation
	localparam int                   W_REFRESH        = 12;
	localparam logic [W_REFRESH-1:0] REFRESH_INTERVAL = 12'd200;

	// --------------------
	// data bus schedule
	// --------------------
	// slot 0 is the previous cycle, slot 1 is now
	localparam int DQ_SCHED_LEN = BURST_LEN + CAS_LATENCY + 2;
	localparam logic [DQ_SCHED_LEN-1:0] DQ_WRITE_MASK =
		{{(DQ_SCHED_LEN - BURST_LEN){1'b0}}, {BURST_LEN{1'b1}}};
	localparam logic [DQ_SCHED_LEN-1:0] DQ_READ_MASK = DQ_WRITE_MASK << (CAS_LATENCY + 1);

endpackage

// File: rtl/sdram_refresh_timer.sv
// refresh interval is fixed in the package and the request holds until a REFRESH issues
`timescale 1ns/1ps

module sdram_refresh_timer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        refresh_en,
	input  logic                        cmd_vld,
	input  sdram_sched_pkg::sdram_cmd_e cmd,
	output logic                        refresh_req
);

	import sdram_sched_pkg::*;

	logic [W_REFRESH-1:0] refresh_ctr;
	logic                 refresh_issued;

	assign refresh_issued = cmd_vld && cmd == CMD_REFRESH;

	// counter keeps running while a request waits
	// subtracting the interval keeps the long-term rate exact
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refresh_ctr <= '0;
			refresh_req <= 1'b0;
		end else if (!refresh_en) begin
			// held idle until the memory has been initialised
			refresh_ctr <= '0;
			refresh_req <= 1'b0;
		end else begin
			refresh_ctr <= refresh_ctr + 1'b1 - (refresh_issued ? REFRESH_INTERVAL : '0);
			refresh_req <= (refresh_req && !refresh_issued) || refresh_ctr == REFRESH_INTERVAL;
		end
	end

	// disabling refresh must drop the request on the next edge
	assert property (@(posedge clk) disable iff (!rst_n)
		!$past(refresh_en) |-> !refresh_req);

endmodule

// File: rtl/sdram_bank_track.sv
// tracks open rows from issued commands only and assumes the command stream is legal
`timescale 1ns/1ps

module sdram_bank_track (
	input  logic                                                       clk,
	input  logic                                                       rst_n,
	input  logic                                                       cmd_vld,
	input  sdram_sched_pkg::sdram_cmd_e                                cmd,
	input  logic [sdram_sched_pkg::W_BANK-1:0]                         cmd_bank,
	input  logic [sdram_sched_pkg::W_ROW-1:0]                          cmd_addr,
	output logic [sdram_sched_pkg::N_BANKS-1:0]                        bank_open,
	output logic [sdram_sched_pkg::N_BANKS*sdram_sched_pkg::W_ROW-1:0] bank_row
);

	import sdram_sched_pkg::*;

	logic pre_issued;
	logic act_issued;
	logic pre_all;

	assign pre_issued = cmd_vld && cmd == CMD_PRECHARGE;
	assign act_issued = cmd_vld && cmd == CMD_ACTIVATE;
	assign pre_all    = cmd_addr[PRECHARGE_ALL_BIT];

	// --------------------
	// open flags
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bank_open <= '0;
		end else begin
			for (int b = 0; b < N_BANKS; b++) begin
				if (pre_issued && (pre_all || cmd_bank == W_BANK'(b))) begin
					bank_open[b] <= 1'b0;
				end else if (act_issued && cmd_bank == W_BANK'(b)) begin
					bank_open[b] <= 1'b1;
				end
			end
		end
	end

	// row only meaningful while the bank is open
	always_ff @(posedge clk) begin
		if (act_issued) begin
			bank_row[cmd_bank*W_ROW +: W_ROW] <= cmd_addr;
		end
	end

	// activate on an open bank would corrupt the row buffer
	assert property (@(posedge clk) disable iff (!rst_n)
		(cmd_vld && cmd == CMD_ACTIVATE) |-> !bank_open[cmd_bank]);

endmodule

// File: rtl/sdram_timing_track.sv
// timing constants come from the package as cycles minus one and counters saturate at zero
`timescale 1ns/1ps

module sdram_timing_track (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                cmd_vld,
	input  sdram_sched_pkg::sdram_cmd_e         cmd,
	input  logic [sdram_sched_pkg::W_BANK-1:0]  cmd_bank,
	input  logic [sdram_sched_pkg::W_ROW-1:0]   cmd_addr,
	output logic [sdram_sched_pkg::N_BANKS-1:0] pre_ok,
	output logic [sdram_sched_pkg::N_BANKS-1:0] act_ok,
	output logic [sdram_sched_pkg::N_BANKS-1:0] cas_ok,
	output logic                                pre_all_ok,
	output logic                                refresh_ok
);

	import sdram_sched_pkg::*;

	// tRC, tRCD, tRP, tRAS and column recovery per bank
	logic [W_TIME-1:0] rc_ctr  [N_BANKS];
	logic [W_TIME-1:0] rcd_ctr [N_BANKS];
	logic [W_TIME-1:0] rp_ctr  [N_BANKS];
	logic [W_TIME-1:0] ras_ctr [N_BANKS];
	logic [W_TIME-1:0] rec_ctr [N_BANKS];
	// tRRD spans all banks
	logic [W_TIME-1:0] rrd_ctr;

	logic act_issued;
	logic pre_issued;
	logic ref_issued;
	logic wr_issued;
	logic rd_issued;

	assign act_issued = cmd_vld && cmd == CMD_ACTIVATE;
	assign pre_issued = cmd_vld && cmd == CMD_PRECHARGE;
	assign ref_issued = cmd_vld && cmd == CMD_REFRESH;
	assign wr_issued  = cmd_vld && cmd == CMD_WRITE;
	assign rd_issued  = cmd_vld && cmd == CMD_READ;

	// --------------------
	// counters
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int b = 0; b < N_BANKS; b++) begin
				rc_ctr[b]  <= '0;
				rcd_ctr[b] <= '0;
				rp_ctr[b]  <= '0;
				ras_ctr[b] <= '0;
				rec_ctr[b] <= '0;
			end
			rrd_ctr <= '0;
		end else begin
			for (int b = 0; b < N_BANKS; b++) begin
				// default is a saturating count down
				rc_ctr[b]  <= rc_ctr[b]  - |rc_ctr[b];
				rcd_ctr[b] <= rcd_ctr[b] - |rcd_ctr[b];
				rp_ctr[b]  <= rp_ctr[b]  - |rp_ctr[b];
				ras_ctr[b] <= ras_ctr[b] - |ras_ctr[b];
				rec_ctr[b] <= rec_ctr[b] - |rec_ctr[b];
				// refresh occupies every bank like an activate
				if ((act_issued && cmd_bank == W_BANK'(b)) || ref_issued) begin
					rc_ctr[b]  <= T_RC;
					rcd_ctr[b] <= T_RCD;
					ras_ctr[b] <= T_RAS;
				end
				if (pre_issued && (cmd_addr[PRECHARGE_ALL_BIT] || cmd_bank == W_BANK'(b))) begin
					rp_ctr[b] <= T_RP;
				end
				// recovery also blocks precharge during a read burst
				if (wr_issued && cmd_bank == W_BANK'(b)) begin
					rec_ctr[b] <= T_WR_RECOVERY;
				end else if (rd_issued && cmd_bank == W_BANK'(b)) begin
					rec_ctr[b] <= T_RD_RECOVERY;
				end
			end
			rrd_ctr <= rrd_ctr - |rrd_ctr;
			if (act_issued) begin
				rrd_ctr <= T_RRD;
			end
		end
	end

	// --------------------
	// permissions
	// --------------------
	always_comb begin
		for (int b = 0; b < N_BANKS; b++) begin
			pre_ok[b] = ~|{ras_ctr[b], rec_ctr[b]};
			act_ok[b] = ~|{rc_ctr[b], rp_ctr[b], rrd_ctr};
			cas_ok[b] = ~|rcd_ctr[b];
		end
	end

	// all-bank forms for precharge-all and refresh
	assign pre_all_ok = &pre_ok;
	assign refresh_ok = &act_ok;

endmodule

// File: rtl/sdram_dq_schedule.sv
// data strobes follow command issue directly and any I/O register delay is left to the PHY
`timescale 1ns/1ps

module sdram_dq_schedule (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        cmd_vld,
	input  sdram_sched_pkg::sdram_cmd_e cmd,
	output logic                        wr_ok,
	output logic                        rd_ok,
	output logic                        dq_write,
	output logic                        dq_read
);

	import sdram_sched_pkg::*;

	// per slot record is {busy, read}
	// slot 0 is last cycle, slot 1 is this cycle
	logic [DQ_SCHED_LEN-1:0] sched_busy;
	logic [DQ_SCHED_LEN-1:0] sched_read;

	logic wr_issued;
	logic rd_issued;

	assign wr_issued = cmd_vld && cmd == CMD_WRITE;
	assign rd_issued = cmd_vld && cmd == CMD_READ;

	// --------------------
	// schedule shift
	// --------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sched_busy <= '0;
			sched_read <= '0;
		end else begin
			sched_busy <= (sched_busy >> 1)
				| (wr_issued ? DQ_WRITE_MASK : '0)
				| (rd_issued ? DQ_READ_MASK : '0);
			sched_read <= (sched_read >> 1) | (rd_issued ? DQ_READ_MASK : '0);
		end
	end

	// --------------------
	// contention checks
	// --------------------
	// write needs the next burst free and no read data on the bus last cycle
	assign wr_ok = ~|sched_busy[BURST_LEN:1] && !(sched_busy[0] && sched_read[0]);

	// read window must be free
	// no write just before the window for turnaround
	// a read during a write burst would cut the write short
	assign rd_ok = ~|(sched_busy & DQ_READ_MASK)
		&& !(sched_busy[CAS_LATENCY] && !sched_read[CAS_LATENCY])
		&& !(sched_busy[1] && !sched_read[1]);

	// first write beat goes out with the command itself
	assign dq_write = wr_issued || (sched_busy[1] && !sched_read[1]);
	assign dq_read  = sched_busy[1] && sched_read[1];

	// command gating must keep the bus one-directional
	assert property (@(posedge clk) disable iff (!rst_n) !(dq_write && dq_read));

endmodule

// File: rtl/sdram_cmd_gen.sv
// one request in flight at a time and the request fields must hold until req_rdy
`timescale 1ns/1ps

module sdram_cmd_gen (
	input  logic                                                       req_vld,
	input  logic [sdram_sched_pkg::W_ROW-1:0]                          req_row,
	input  logic [sdram_sched_pkg::W_BANK-1:0]                         req_bank,
	input  logic [sdram_sched_pkg::W_COL-1:0]                          req_col,
	input  logic                                                       req_write,
	input  logic                                                       refresh_req,
	input  logic [sdram_sched_pkg::N_BANKS-1:0]                        bank_open,
	input  logic [sdram_sched_pkg::N_BANKS*sdram_sched_pkg::W_ROW-1:0] bank_row,
	input  logic [sdram_sched_pkg::N_BANKS-1:0]                        pre_ok,
	input  logic [sdram_sched_pkg::N_BANKS-1:0]                        act_ok,
	input  logic [sdram_sched_pkg::N_BANKS-1:0]                        cas_ok,
	input  logic                                                       pre_all_ok,
	input  logic                                                       refresh_ok,
	input  logic                                                       wr_ok,
	input  logic                                                       rd_ok,
	output logic                                                       req_rdy,
	output logic                                                       cmd_vld,
	output sdram_sched_pkg::sdram_cmd_e                                cmd,
	output logic [sdram_sched_pkg::W_ROW-1:0]                          cmd_addr,
	output logic [sdram_sched_pkg::W_BANK-1:0]                         cmd_bank
);

	import sdram_sched_pkg::*;

	logic [W_ROW-1:0] open_row;
	logic             is_burst;

	assign open_row = bank_row[req_bank*W_ROW +: W_ROW];

	// --------------------
	// command choice
	// --------------------
	// refresh wins over the request
	always_comb begin
		if (refresh_req && |bank_open) begin
			cmd = CMD_PRECHARGE;
		end else if (refresh_req) begin
			cmd = CMD_REFRESH;
		end else if (!bank_open[req_bank]) begin
			cmd = CMD_ACTIVATE;
		end else if (open_row != req_row) begin
			// page miss
			cmd = CMD_PRECHARGE;
		end else if (req_write) begin
			cmd = CMD_WRITE;
		end else begin
			cmd = CMD_READ;
		end
	end

	// --------------------
	// address and permission
	// --------------------
	always_comb begin
		cmd_vld  = 1'b0;
		cmd_addr = '0;
		case (cmd)
			CMD_PRECHARGE: begin
				if (refresh_req) begin
					cmd_vld                     = pre_all_ok;
					cmd_addr[PRECHARGE_ALL_BIT] = 1'b1;
				end else begin
					cmd_vld = req_vld && pre_ok[req_bank];
				end
			end
			CMD_REFRESH:  cmd_vld = refresh_ok;
			CMD_ACTIVATE: begin
				cmd_vld  = req_vld && act_ok[req_bank];
				cmd_addr = req_row;
			end
			CMD_WRITE, CMD_READ: begin
				// tRCD plus data bus turnaround
				cmd_vld  = req_vld && cas_ok[req_bank] && (req_write ? wr_ok : rd_ok);
				cmd_addr = W_ROW'(req_col);
			end
			default: cmd_vld = 1'b0;
		endcase
	end

	// bank is ignored by refresh and precharge-all
	assign cmd_bank = req_bank;
	assign is_burst = cmd == CMD_WRITE || cmd == CMD_READ;
	// request completes with its column command
	assign req_rdy  = cmd_vld && is_burst;

endmodule

// File: rtl/sdram_scheduler.sv
// single requester with fixed timing and strobes aligned to the command edge
`timescale 1ns/1ps

module sdram_scheduler (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                refresh_en,
	input  logic                                req_vld,
	output logic                                req_rdy,
	input  logic [sdram_sched_pkg::W_ROW-1:0]   req_row,
	input  logic [sdram_sched_pkg::W_BANK-1:0]  req_bank,
	input  logic [sdram_sched_pkg::W_COL-1:0]   req_col,
	input  logic                                req_write,
	output logic                                cmd_vld,
	output logic                                cmd_ras_n,
	output logic                                cmd_cas_n,
	output logic                                cmd_we_n,
	output logic [sdram_sched_pkg::W_ROW-1:0]   cmd_addr,
	output logic [sdram_sched_pkg::W_BANK-1:0]  cmd_bank,
	output logic                                dq_write,
	output logic                                dq_read
);

	import sdram_sched_pkg::*;

	sdram_cmd_e                 cmd;
	logic                       refresh_req;
	logic [N_BANKS-1:0]         bank_open;
	logic [N_BANKS*W_ROW-1:0]   bank_row;
	logic [N_BANKS-1:0]         pre_ok;
	logic [N_BANKS-1:0]         act_ok;
	logic [N_BANKS-1:0]         cas_ok;
	logic                       pre_all_ok;
	logic                       refresh_ok;
	logic                       wr_ok;
	logic                       rd_ok;

	// enum bits map straight onto the pins
	assign {cmd_ras_n, cmd_cas_n, cmd_we_n} = cmd;

	// --------------------
	// state trackers
	// --------------------
	sdram_refresh_timer refresh_i (
		.clk(clk), .rst_n(rst_n), .refresh_en(refresh_en),
		.cmd_vld(cmd_vld), .cmd(cmd), .refresh_req(refresh_req)
	);

	sdram_bank_track bank_i (
		.clk(clk), .rst_n(rst_n), .cmd_vld(cmd_vld), .cmd(cmd),
		.cmd_bank(cmd_bank), .cmd_addr(cmd_addr),
		.bank_open(bank_open), .bank_row(bank_row)
	);

	sdram_timing_track timing_i (
		.clk(clk), .rst_n(rst_n), .cmd_vld(cmd_vld), .cmd(cmd),
		.cmd_bank(cmd_bank), .cmd_addr(cmd_addr),
		.pre_ok(pre_ok), .act_ok(act_ok), .cas_ok(cas_ok),
		.pre_all_ok(pre_all_ok), .refresh_ok(refresh_ok)
	);

	sdram_dq_schedule dq_i (
		.clk(clk), .rst_n(rst_n), .cmd_vld(cmd_vld), .cmd(cmd),
		.wr_ok(wr_ok), .rd_ok(rd_ok), .dq_write(dq_write), .dq_read(dq_read)
	);

	// --------------------
	// command selection
	// --------------------
	sdram_cmd_gen cmd_gen_i (
		.req_vld(req_vld), .req_row(req_row), .req_bank(req_bank),
		.req_col(req_col), .req_write(req_write),
		.refresh_req(refresh_req), .bank_open(bank_open), .bank_row(bank_row),
		.pre_ok(pre_ok), .act_ok(act_ok), .cas_ok(cas_ok),
		.pre_all_ok(pre_all_ok), .refresh_ok(refresh_ok),
		.wr_ok(wr_ok), .rd_ok(rd_ok),
		.req_rdy(req_rdy), .cmd_vld(cmd_vld), .cmd(cmd),
		.cmd_addr(cmd_addr), .cmd_bank(cmd_bank)
	);

endmodule

// File: testbench/tb_sdram_scheduler.sv
// the bank model follows observed commands only and the refresh gap bound is the interval plus 40
`timescale 1ns/1ps

module tb_sdram_scheduler;

	import sdram_sched_pkg::*;

	localparam int N_REQ_NOREF      = 60;
	localparam int N_REQ_REF        = 200;
	localparam int N_REQ_TAIL       = 20;
	localparam int N_REQ            = N_REQ_NOREF + N_REQ_REF + N_REQ_TAIL;
	localparam int IDLE_CYCLES      = 20;
	localparam int REF_IDLE_CYCLES  = 300;
	// refresh sequence, row cycle, burst and the longest gap between requests
	localparam int WORST_REQ_CYCLES = 56;
	localparam int WATCHDOG_CYCLES  =
		16 + 3 * IDLE_CYCLES + REF_IDLE_CYCLES + N_REQ * WORST_REQ_CYCLES;
	localparam int REFRESH_BOUND    = int'(REFRESH_INTERVAL) + 40;
	localparam int NEVER            = -1000;
	// two rows per bank give page hits and page misses
	localparam logic [1:0][W_ROW-1:0] ROW_POOL = {13'h1a5c, 13'h0123};

	logic               clk;
	logic               rst_n;
	logic               refresh_en;
	logic               req_vld;
	logic               req_rdy;
	logic [W_ROW-1:0]   req_row;
	logic [W_BANK-1:0]  req_bank;
	logic [W_COL-1:0]   req_col;
	logic               req_write;
	logic               cmd_vld;
	logic               cmd_ras_n;
	logic               cmd_cas_n;
	logic               cmd_we_n;
	logic [W_ROW-1:0]   cmd_addr;
	logic [W_BANK-1:0]  cmd_bank;
	logic               dq_write;
	logic               dq_read;

	sdram_cmd_e         cmd_obs;
	logic               act_cmd;
	logic               pre_cmd;
	logic               ref_cmd;
	logic               burst_cmd;

	// --------------------
	// reference model
	// --------------------
	int                 cyc;
	logic [N_BANKS-1:0] m_open;
	logic [W_ROW-1:0]   m_row [N_BANKS];
	int                 last_act [N_BANKS];
	int                 last_pre [N_BANKS];
	int                 last_act_any;
	int                 last_wr;
	int                 last_rd;
	int                 prev_rd;
	int                 ref_base;
	int                 gap_act_bank;
	int                 gap_act_any;
	int                 gap_pre_bank;
	int                 gap_ref;
	logic               ras_met_all;
	logic               exp_dq_write;
	logic               exp_dq_read;

	int                 errors = 0;
	int                 n_req = 0;
	int                 n_refresh = 0;
	logic [31:0]        lfsr_state;

	sdram_scheduler dut_i (
		.clk(clk), .rst_n(rst_n), .refresh_en(refresh_en),
		.req_vld(req_vld), .req_rdy(req_rdy), .req_row(req_row),
		.req_bank(req_bank), .req_col(req_col), .req_write(req_write),
		.cmd_vld(cmd_vld), .cmd_ras_n(cmd_ras_n), .cmd_cas_n(cmd_cas_n),
		.cmd_we_n(cmd_we_n), .cmd_addr(cmd_addr), .cmd_bank(cmd_bank),
		.dq_write(dq_write), .dq_read(dq_read)
	);

	// pins back to the enum
	assign cmd_obs   = sdram_cmd_e'({cmd_ras_n, cmd_cas_n, cmd_we_n});
	assign act_cmd   = cmd_vld && cmd_obs == CMD_ACTIVATE;
	assign pre_cmd   = cmd_vld && cmd_obs == CMD_PRECHARGE;
	assign ref_cmd   = cmd_vld && cmd_obs == CMD_REFRESH;
	assign burst_cmd = cmd_vld && (cmd_obs == CMD_WRITE || cmd_obs == CMD_READ);

	function automatic logic in_read_window(input int d);
		return d >= CAS_LATENCY + 1 && d <= CAS_LATENCY + BURST_LEN;
	endfunction

	// cyc numbers the edge at which a command is sampled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyc          <= 0;
			m_open       <= '0;
			last_act_any <= NEVER;
			last_wr      <= NEVER;
			last_rd      <= NEVER;
			prev_rd      <= NEVER;
			ref_base     <= 0;
			for (int b = 0; b < N_BANKS; b++) begin
				last_act[b] <= NEVER;
				last_pre[b] <= NEVER;
			end
		end else begin
			cyc <= cyc + 1;
			if (act_cmd) begin
				m_open[cmd_bank]   <= 1'b1;
				m_row[cmd_bank]    <= cmd_addr;
				last_act[cmd_bank] <= cyc;
				last_act_any       <= cyc;
			end
			for (int b = 0; b < N_BANKS; b++) begin
				if (pre_cmd && (cmd_addr[PRECHARGE_ALL_BIT] || cmd_bank == W_BANK'(b))) begin
					m_open[b]   <= 1'b0;
					last_pre[b] <= cyc;
				end
			end
			if (cmd_vld && cmd_obs == CMD_WRITE) begin
				last_wr <= cyc;
			end
			// two reads can have data on the bus in one window
			if (cmd_vld && cmd_obs == CMD_READ) begin
				prev_rd <= last_rd;
				last_rd <= cyc;
			end
			// refresh gap counts from enable or from the last REFRESH
			if (!refresh_en || ref_cmd) begin
				ref_base <= cyc;
			end
			if (ref_cmd) begin
				n_refresh <= n_refresh + 1;
			end
		end
	end

	always_comb begin
		gap_act_bank = cyc - last_act[cmd_bank];
		gap_act_any  = cyc - last_act_any;
		gap_pre_bank = cyc - last_pre[cmd_bank];
		gap_ref      = cyc - ref_base;
		ras_met_all  = 1'b1;
		for (int b = 0; b < N_BANKS; b++) begin
			if (m_open[b] && cyc - last_act[b] < int'(T_RAS) + 1) begin
				ras_met_all = 1'b0;
			end
		end
		// first write beat rides with the command
		exp_dq_write = (cmd_vld && cmd_obs == CMD_WRITE)
			|| (cyc - last_wr >= 1 && cyc - last_wr <= BURST_LEN - 1);
		exp_dq_read  = in_read_window(cyc - last_rd) || in_read_window(cyc - prev_rd);
	end

	// --------------------
	// checks
	// --------------------
	// idle with refresh off for two edges
	a_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(!req_vld && !refresh_en && !$past(refresh_en)) |-> (!cmd_vld && !req_rdy))
		else begin
			errors++;
			$display("command or ready seen with no request and refresh disabled");
		end

	a_act_closed: assert property (@(posedge clk) disable iff (!rst_n)
		act_cmd |-> (req_vld && !m_open[cmd_bank]))
		else begin
			errors++;
			$display("ACTIVATE issued to an open bank or without a request");
		end

	a_act_row: assert property (@(posedge clk) disable iff (!rst_n)
		act_cmd |-> cmd_addr == req_row)
		else begin
			errors++;
			$display("** Error: cmd_addr = %h, expected req_row %h",
				$sampled(cmd_addr), $sampled(req_row));
		end

	a_bank: assert property (@(posedge clk) disable iff (!rst_n)
		(act_cmd || burst_cmd) |-> cmd_bank == req_bank)
		else begin
			errors++;
			$display("** Error: cmd_bank = %h, expected %h", $sampled(cmd_bank), $sampled(req_bank));
		end

	// bank precharge only on a page miss
	a_pre_miss: assert property (@(posedge clk) disable iff (!rst_n)
		(pre_cmd && !cmd_addr[PRECHARGE_ALL_BIT]) |->
			(req_vld && m_open[req_bank] && m_row[req_bank] != req_row))
		else begin
			errors++;
			$display("PRECHARGE issued without a page miss");
		end

	a_pre_all: assert property (@(posedge clk) disable iff (!rst_n)
		(pre_cmd && cmd_addr[PRECHARGE_ALL_BIT]) |-> |m_open)
		else begin
			errors++;
			$display("precharge-all issued with every bank closed");
		end

	a_burst_page: assert property (@(posedge clk) disable iff (!rst_n)
		burst_cmd |-> (req_vld && m_open[cmd_bank] && m_row[cmd_bank] == req_row))
		else begin
			errors++;
			$display("column command issued outside the requested open row");
		end

	a_burst_col: assert property (@(posedge clk) disable iff (!rst_n)
		burst_cmd |-> cmd_addr == W_ROW'(req_col))
		else begin
			errors++;
			$display("** Error: cmd_addr = %h, expected req_col %h",
				$sampled(cmd_addr), $sampled(req_col));
		end

	a_rdy: assert property (@(posedge clk) disable iff (!rst_n)
		req_rdy == (burst_cmd && (cmd_obs == CMD_WRITE) == req_write))
		else begin
			errors++;
			$display("** Error: req_rdy = %h, expected %h", $sampled(req_rdy),
				$sampled(burst_cmd && (cmd_obs == CMD_WRITE) == req_write));
		end

	// spacing between issued commands
	a_trcd: assert property (@(posedge clk) disable iff (!rst_n)
		burst_cmd |-> gap_act_bank >= int'(T_RCD) + 1)
		else begin
			errors++;
			$display("column command %0d cycles after ACTIVATE breaks tRCD", $sampled(gap_act_bank));
		end

	a_trc: assert property (@(posedge clk) disable iff (!rst_n)
		act_cmd |-> gap_act_bank >= int'(T_RC) + 1)
		else begin
			errors++;
			$display("ACTIVATE %0d cycles after ACTIVATE to the bank breaks tRC",
				$sampled(gap_act_bank));
		end

	a_trrd: assert property (@(posedge clk) disable iff (!rst_n)
		act_cmd |-> gap_act_any >= int'(T_RRD) + 1)
		else begin
			errors++;
			$display("ACTIVATE %0d cycles after any ACTIVATE breaks tRRD", $sampled(gap_act_any));
		end

	a_trp: assert property (@(posedge clk) disable iff (!rst_n)
		act_cmd |-> gap_pre_bank >= int'(T_RP) + 1)
		else begin
			errors++;
			$display("ACTIVATE %0d cycles after PRECHARGE breaks tRP", $sampled(gap_pre_bank));
		end

	a_tras: assert property (@(posedge clk) disable iff (!rst_n)
		pre_cmd |-> (cmd_addr[PRECHARGE_ALL_BIT] ? ras_met_all
			: gap_act_bank >= int'(T_RAS) + 1))
		else begin
			errors++;
			$display("PRECHARGE issued before tRAS elapsed");
		end

	// data strobes
	a_dq_write: assert property (@(posedge clk) disable iff (!rst_n) dq_write == exp_dq_write)
		else begin
			errors++;
			$display("** Error: dq_write = %h, expected %h", $sampled(dq_write),
				$sampled(exp_dq_write));
		end

	a_dq_read: assert property (@(posedge clk) disable iff (!rst_n) dq_read == exp_dq_read)
		else begin
			errors++;
			$display("** Error: dq_read = %h, expected %h", $sampled(dq_read), $sampled(exp_dq_read));
		end

	a_dq_excl: assert property (@(posedge clk) disable iff (!rst_n) !(dq_write && dq_read))
		else begin
			errors++;
			$display("dq_write and dq_read high together");
		end

	// refresh
	a_ref_closed: assert property (@(posedge clk) disable iff (!rst_n) ref_cmd |-> m_open == '0)
		else begin
			errors++;
			$display("** Error: bank_open = %h at REFRESH, expected %h", $sampled(m_open), 4'h0);
		end

	a_ref_off: assert property (@(posedge clk) disable iff (!rst_n)
		(!refresh_en && !$past(refresh_en)) |-> !ref_cmd)
		else begin
			errors++;
			$display("REFRESH issued while refresh is disabled");
		end

	a_ref_gap: assert property (@(posedge clk) disable iff (!rst_n)
		refresh_en |-> gap_ref <= REFRESH_BOUND)
		else begin
			errors++;
			$display("no REFRESH within %0d cycles", REFRESH_BOUND);
		end

	// --------------------
	// stimulus
	// --------------------
	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// entered and left 1 ns after a rising edge
	task automatic send_request();
		logic [31:0] r;
		logic        done;
		draw_bits(1, r);
		req_row = ROW_POOL[r[0]];
		draw_bits(W_BANK, r);
		req_bank = r[W_BANK-1:0];
		draw_bits(W_COL, r);
		req_col = r[W_COL-1:0];
		draw_bits(1, r);
		req_write = r[0];
		req_vld = 1'b1;
		done = 1'b0;
		// ready is settled by mid cycle
		while (!done) begin
			@(negedge clk);
			done = req_rdy;
			@(posedge clk);
		end
		#1;
		req_vld = 1'b0;
		n_req++;
		// sometimes leave the bus idle for a few cycles
		draw_bits(1, r);
		if (r[0]) begin
			draw_bits(3, r);
			repeat (int'(r[2:0])) begin
				@(posedge clk);
				#1;
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		lfsr_state = 32'h3634;
		rst_n      = 1'b0;
		refresh_en = 1'b0;
		req_vld    = 1'b0;
		req_row    = '0;
		req_bank   = '0;
		req_col    = '0;
		req_write  = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (IDLE_CYCLES) @(posedge clk);
		#1;
		repeat (N_REQ_NOREF) send_request();
		refresh_en = 1'b1;
		repeat (N_REQ_REF / 2) send_request();
		// long enough for a refresh with nothing waiting
		repeat (REF_IDLE_CYCLES) @(posedge clk);
		#1;
		repeat (N_REQ_REF - N_REQ_REF / 2) send_request();
		refresh_en = 1'b0;
		repeat (N_REQ_TAIL) send_request();
		repeat (IDLE_CYCLES) @(posedge clk);
		if (n_refresh == 0) begin
			errors++;
			$display("no REFRESH seen while refresh was enabled");
		end
		$display("requests %0d, refreshes %0d, errors %0d", n_req, n_refresh, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * 8);
		$display("timeout after %0d cycles with %0d requests done", WATCHDOG_CYCLES, n_req);
		$display("requests %0d, refreshes %0d, errors %0d", n_req, n_refresh, errors + 1);
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: sdram_scheduler.f
rtl/sdram_sched_pkg.sv
rtl/sdram_refresh_timer.sv
rtl/sdram_bank_track.sv
rtl/sdram_timing_track.sv
rtl/sdram_dq_schedule.sv
rtl/sdram_cmd_gen.sv
rtl/sdram_scheduler.sv
testbench/tb_sdram_scheduler.sv
